//--- verilog/lsu_pkg.sv
/*
 * core-side load/store definitions
 * - access control word seen on i_ctrl
 * - size codes and the unsigned flag position
 */
package lsu_pkg;

   // bits 1:0 give the size, bit 2 asks for zero extension
   typedef logic [2:0] ctrl_t;

   // size codes, as the core encodes funct3[1:0]
   localparam logic [1:0] SIZE_BYTE = 2'd0;
   localparam logic [1:0] SIZE_HALF = 2'd1;
   localparam logic [1:0] SIZE_WORD = 2'd2;

   localparam int UNSIGNED_BIT = 2;   // lbu / lhu

endpackage

//--- verilog/dram_pkg.sv
/*
 * DRAM side definitions
 * - data word, byte mask and word address types
 * - default depth, busy times and refresh thresholds
 */
package dram_pkg;

   localparam int WADDR_W = 30;   // word index taken from a 32-bit byte address

   typedef logic [31:0]        word_t;
   typedef logic [3:0]         mask_t;   // bit n enables byte lane n
   typedef logic [WADDR_W-1:0] waddr_t;

   localparam int DEF_MEM_WORDS        = 1024;
   localparam int DEF_ACCESS_CYCLES    = 3;
   localparam int DEF_REFRESH_CYCLES   = 5;
   localparam int DEF_REFRESH_INTERVAL = 200;   // idle cycles before a refresh is asked for
   localparam int DEF_REFRESH_MAX      = 405;   // past this the refresh counts as late

endpackage

//--- verilog/refresh_timer.sv
/*
 * refresh timer
 * - counts cycles since the last refresh
 * - refresh request past the interval, sticky late flag past the maximum
 */
module refresh_timer #(
   parameter int REFRESH_INTERVAL = dram_pkg::DEF_REFRESH_INTERVAL,
   parameter int REFRESH_MAX      = dram_pkg::DEF_REFRESH_MAX
) (
   input  logic clk,
   input  logic rst_x,
   input  logic i_refresh_done,
   output logic o_refresh_req,
   output logic o_late_refresh
);

   // saturate just above the larger threshold
   localparam int CNT_TOP = ((REFRESH_INTERVAL > REFRESH_MAX) ? REFRESH_INTERVAL
                                                              : REFRESH_MAX) + 1;
   localparam int CNT_W   = $clog2(CNT_TOP + 1);

   logic [CNT_W-1:0] r_cnt;

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_cnt          <= '0;
         o_late_refresh <= 1'b0;
      end else begin
         if (i_refresh_done)
            r_cnt <= '0;
         else if (r_cnt != CNT_W'(CNT_TOP))
            r_cnt <= r_cnt + 1'b1;
         if (r_cnt > CNT_W'(REFRESH_MAX))
            o_late_refresh <= 1'b1;   // cleared only by reset
      end
   end

   assign o_refresh_req = (r_cnt > CNT_W'(REFRESH_INTERVAL));

endmodule

//--- verilog/word_dram_model.sv
/*
 * behavioral DRAM word memory
 * - byte-masked writes, wrapped word address
 * - busy counter for access and refresh time
 */
module word_dram_model #(
   parameter int MEM_WORDS      = dram_pkg::DEF_MEM_WORDS,
   parameter int ACCESS_CYCLES  = dram_pkg::DEF_ACCESS_CYCLES,
   parameter int REFRESH_CYCLES = dram_pkg::DEF_REFRESH_CYCLES
) (
   input  logic             clk,
   input  logic             rst_x,
   input  logic             i_rd,
   input  logic             i_wr,
   input  logic             i_refresh,
   input  dram_pkg::waddr_t i_addr,
   input  dram_pkg::word_t  i_wdata,
   input  dram_pkg::mask_t  i_mask,
   output logic             o_busy,
   output dram_pkg::word_t  o_rdata
);

   localparam int IDX_W    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
   localparam int BUSY_MAX = (ACCESS_CYCLES > REFRESH_CYCLES) ? ACCESS_CYCLES
                                                              : REFRESH_CYCLES;
   localparam int CNT_W    = $clog2(BUSY_MAX + 1);

   dram_pkg::word_t  mem [MEM_WORDS];
   logic [CNT_W-1:0] r_cnt;
   logic             r_rd_pend;    // read waiting for busy to end
   logic [IDX_W-1:0] r_rd_idx;
   logic [IDX_W-1:0] w_idx;

   initial begin
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = '0;
   end

   assign w_idx  = IDX_W'(i_addr % MEM_WORDS);   // wrap to depth
   assign o_busy = (r_cnt != '0);

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_cnt     <= '0;
         r_rd_pend <= 1'b0;
      end else if (i_refresh) begin
         r_cnt <= CNT_W'(REFRESH_CYCLES);
      end else if (i_rd || i_wr) begin
         r_cnt     <= CNT_W'(ACCESS_CYCLES);
         r_rd_pend <= i_rd;
      end else if (r_cnt != '0) begin
         r_cnt <= r_cnt - 1'b1;
         if (r_cnt == CNT_W'(1))
            r_rd_pend <= 1'b0;
      end
   end

   // write lands at the strobe, read data shows up as busy drops
   always @(posedge clk) begin
      if (i_wr) begin
         for (int n = 0; n < 4; n++) begin
            if (i_mask[n])
               mem[w_idx][8*n +: 8] <= i_wdata[8*n +: 8];
         end
      end
      if (i_rd)
         r_rd_idx <= w_idx;
      if (r_rd_pend && (r_cnt == CNT_W'(1)))
         o_rdata <= mem[r_rd_idx];
   end

endmodule

//--- verilog/load_align.sv
/*
 * load aligner
 * - shifts the two-word pair by the byte offset
 * - sign or zero extension, result registered on capture
 */
module load_align (
   input  logic            clk,
   input  logic            rst_x,
   input  logic            i_capture,
   input  dram_pkg::word_t i_lo,
   input  dram_pkg::word_t i_hi,
   input  logic [1:0]      i_offset,
   input  lsu_pkg::ctrl_t  i_ctrl,
   output dram_pkg::word_t o_data
);

   logic [63:0]     w_pair;
   logic            w_unsigned;
   dram_pkg::word_t w_ext;

   assign w_pair     = {i_hi, i_lo} >> {i_offset, 3'b000};
   assign w_unsigned = i_ctrl[lsu_pkg::UNSIGNED_BIT];

   always_comb begin
      case (i_ctrl[1:0])
         lsu_pkg::SIZE_BYTE: w_ext = {{24{~w_unsigned & w_pair[7]}}, w_pair[7:0]};
         lsu_pkg::SIZE_HALF: w_ext = {{16{~w_unsigned & w_pair[15]}}, w_pair[15:0]};
         default:            w_ext = w_pair[31:0];
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_x)
         o_data <= '0;
      else if (i_capture)
         o_data <= w_ext;   // held until the next load completes
   end

endmodule

//--- verilog/unaligned_access_ctrl.sv
/*
 * access splitter for byte, half and word loads/stores
 * - turns one core access into one or two masked word accesses
 * - slots refresh strobes in between core accesses
 */
module unaligned_access_ctrl (
   input  logic             clk,
   input  logic             rst_x,
   input  logic             i_rd_en,
   input  logic             i_wr_en,
   input  logic [31:0]      i_addr,
   input  dram_pkg::word_t  i_data,
   input  lsu_pkg::ctrl_t   i_ctrl,
   input  logic             i_dram_busy,
   input  dram_pkg::word_t  i_dram_rdata,
   input  logic             i_refresh_req,
   output logic             o_busy,
   output logic             o_dram_rd,
   output logic             o_dram_wr,
   output logic             o_dram_refresh,
   output dram_pkg::waddr_t o_dram_addr,
   output dram_pkg::word_t  o_dram_wdata,
   output dram_pkg::mask_t  o_dram_mask,
   output dram_pkg::word_t  o_load_lo,
   output dram_pkg::word_t  o_load_hi,
   output logic             o_load_capture,
   output logic [1:0]       o_load_offset,
   output lsu_pkg::ctrl_t   o_load_ctrl
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_ISSUE,     // strobe is on the bus
      S_WAIT,      // word access in flight
      S_REFRESH
   } state_t;

   state_t           r_state;
   logic             r_stall;
   logic             r_is_load;
   logic             r_cross;       // access spans two words
   logic             r_second;      // upper word in progress
   dram_pkg::word_t  r_lo;          // first word of a crossing load
   dram_pkg::word_t  r_hi_wdata;
   dram_pkg::mask_t  r_hi_mask;
   logic [1:0]       r_offset;
   lsu_pkg::ctrl_t   r_ctrl;

   logic [31:0]      w_sized;
   logic [3:0]       w_lanes;
   logic [63:0]      w_wdata64;     // store data across both words
   logic [7:0]       w_mask8;
   logic             w_accept;
   logic             w_last;

   // size the store data and pick the lanes at offset 0
   always_comb begin
      case (i_ctrl[1:0])
         lsu_pkg::SIZE_BYTE: begin
            w_sized = {24'h0, i_data[7:0]};
            w_lanes = 4'b0001;
         end
         lsu_pkg::SIZE_HALF: begin
            w_sized = {16'h0, i_data[15:0]};
            w_lanes = 4'b0011;
         end
         default: begin
            w_sized = i_data;
            w_lanes = 4'b1111;
         end
      endcase
   end

   assign w_wdata64 = {32'h0, w_sized} << {i_addr[1:0], 3'b000};
   assign w_mask8   = {4'h0, w_lanes} << i_addr[1:0];   // upper nibble set when crossing

   assign o_busy   = r_stall | i_dram_busy;
   assign w_accept = (r_state == S_IDLE) && !o_busy && (i_rd_en || i_wr_en);
   assign w_last   = !r_cross || r_second;

   // dram read data holds until the next read, so the last word comes straight through
   assign o_load_lo      = r_second ? r_lo : i_dram_rdata;
   assign o_load_hi      = i_dram_rdata;
   assign o_load_capture = (r_state == S_WAIT) && !i_dram_busy && r_is_load && w_last;
   assign o_load_offset  = r_offset;
   assign o_load_ctrl    = r_ctrl;

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         r_state        <= S_IDLE;
         r_stall        <= 1'b0;
         r_second       <= 1'b0;
         o_dram_rd      <= 1'b0;
         o_dram_wr      <= 1'b0;
         o_dram_refresh <= 1'b0;
      end else begin
         case (r_state)
            S_IDLE: begin
               if (w_accept) begin
                  r_stall      <= 1'b1;
                  r_second     <= 1'b0;
                  r_is_load    <= i_rd_en;        // read wins over write
                  r_cross      <= |w_mask8[7:4];
                  r_offset     <= i_addr[1:0];
                  r_ctrl       <= i_ctrl;
                  o_dram_rd    <= i_rd_en;
                  o_dram_wr    <= !i_rd_en;
                  o_dram_addr  <= i_addr[31:2];
                  o_dram_wdata <= w_wdata64[31:0];
                  o_dram_mask  <= w_mask8[3:0];
                  r_hi_wdata   <= w_wdata64[63:32];
                  r_hi_mask    <= w_mask8[7:4];
                  r_state      <= S_ISSUE;
               end else if (i_refresh_req && !o_busy) begin
                  // stall only over the strobe cycle, dram busy takes over after
                  r_stall        <= 1'b1;
                  o_dram_refresh <= 1'b1;
                  r_state        <= S_REFRESH;
               end
            end
            S_ISSUE: begin
               o_dram_rd <= 1'b0;
               o_dram_wr <= 1'b0;
               r_state   <= S_WAIT;
            end
            S_WAIT: begin
               if (!i_dram_busy) begin
                  if (w_last) begin
                     r_stall <= 1'b0;
                     r_state <= S_IDLE;
                  end else begin
                     // spill into the next word
                     r_second     <= 1'b1;
                     r_lo         <= i_dram_rdata;
                     o_dram_rd    <= r_is_load;
                     o_dram_wr    <= !r_is_load;
                     o_dram_addr  <= o_dram_addr + 1'b1;
                     o_dram_wdata <= r_hi_wdata;
                     o_dram_mask  <= r_hi_mask;
                     r_state      <= S_ISSUE;
                  end
               end
            end
            S_REFRESH: begin
               o_dram_refresh <= 1'b0;
               r_stall        <= 1'b0;
               r_state        <= S_IDLE;
            end
            default: r_state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- verilog/dram_subsystem_top.sv
/*
 * data memory subsystem top
 * - access splitter, refresh timer, DRAM model and load aligner
 */
module dram_subsystem_top #(
   parameter int MEM_WORDS        = dram_pkg::DEF_MEM_WORDS,
   parameter int ACCESS_CYCLES    = dram_pkg::DEF_ACCESS_CYCLES,
   parameter int REFRESH_CYCLES   = dram_pkg::DEF_REFRESH_CYCLES,
   parameter int REFRESH_INTERVAL = dram_pkg::DEF_REFRESH_INTERVAL,
   parameter int REFRESH_MAX      = dram_pkg::DEF_REFRESH_MAX
) (
   input  logic            clk,
   input  logic            rst_x,
   input  logic            i_rd_en,
   input  logic            i_wr_en,
   input  logic [31:0]     i_addr,
   input  dram_pkg::word_t i_data,
   input  lsu_pkg::ctrl_t  i_ctrl,
   output dram_pkg::word_t o_data,
   output logic            o_busy,
   output logic            o_late_refresh
);

   logic             dram_rd;
   logic             dram_wr;
   logic             dram_refresh;
   logic             dram_busy;
   dram_pkg::waddr_t dram_addr;
   dram_pkg::word_t  dram_wdata;
   dram_pkg::mask_t  dram_mask;
   dram_pkg::word_t  dram_rdata;
   logic             refresh_req;
   dram_pkg::word_t  load_lo;
   dram_pkg::word_t  load_hi;
   logic             load_capture;
   logic [1:0]       load_offset;
   lsu_pkg::ctrl_t   load_ctrl;

   unaligned_access_ctrl unaligned_access_ctrl_inst (
      .clk(clk), .rst_x(rst_x),
      .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr), .i_data(i_data),
      .i_ctrl(i_ctrl), .i_dram_busy(dram_busy), .i_dram_rdata(dram_rdata),
      .i_refresh_req(refresh_req), .o_busy(o_busy),
      .o_dram_rd(dram_rd), .o_dram_wr(dram_wr), .o_dram_refresh(dram_refresh),
      .o_dram_addr(dram_addr), .o_dram_wdata(dram_wdata), .o_dram_mask(dram_mask),
      .o_load_lo(load_lo), .o_load_hi(load_hi), .o_load_capture(load_capture),
      .o_load_offset(load_offset), .o_load_ctrl(load_ctrl)
   );

   refresh_timer #(
      .REFRESH_INTERVAL(REFRESH_INTERVAL),
      .REFRESH_MAX(REFRESH_MAX)
   ) refresh_timer_inst (
      .clk(clk), .rst_x(rst_x), .i_refresh_done(dram_refresh),
      .o_refresh_req(refresh_req), .o_late_refresh(o_late_refresh)
   );

   word_dram_model #(
      .MEM_WORDS(MEM_WORDS),
      .ACCESS_CYCLES(ACCESS_CYCLES),
      .REFRESH_CYCLES(REFRESH_CYCLES)
   ) word_dram_model_inst (
      .clk(clk), .rst_x(rst_x), .i_rd(dram_rd), .i_wr(dram_wr), .i_refresh(dram_refresh),
      .i_addr(dram_addr), .i_wdata(dram_wdata), .i_mask(dram_mask),
      .o_busy(dram_busy), .o_rdata(dram_rdata)
   );

   load_align load_align_inst (
      .clk(clk), .rst_x(rst_x), .i_capture(load_capture), .i_lo(load_lo), .i_hi(load_hi),
      .i_offset(load_offset), .i_ctrl(load_ctrl), .o_data(o_data)
   );

endmodule

//--- verif/tb_assertions.sv
/*
 * concurrent checks bound to the access splitter
 * - exclusive DRAM strobes, no strobe into a busy DRAM
 * - o_busy held until every word of an accepted access is issued
 */
module tb_assertions (
   input logic           clk,
   input logic           rst_x,
   input logic           i_rd_en,
   input logic           i_wr_en,
   input logic [31:0]    i_addr,
   input lsu_pkg::ctrl_t i_ctrl,
   input logic           i_dram_busy,
   input logic           o_busy,
   input logic           o_dram_rd,
   input logic           o_dram_wr,
   input logic           o_dram_refresh
);

   logic       w_strobe;
   logic       w_accept;
   logic [2:0] w_nbytes;
   logic       w_cross;    // access spans two words
   logic [1:0] r_words;    // word strobes still owed to the current access

   assign w_strobe = o_dram_rd | o_dram_wr | o_dram_refresh;
   assign w_accept = !o_busy && (i_rd_en || i_wr_en);   // idle whenever busy is low

   always_comb begin
      case (i_ctrl[1:0])
         lsu_pkg::SIZE_BYTE: w_nbytes = 3'd1;
         lsu_pkg::SIZE_HALF: w_nbytes = 3'd2;
         default:            w_nbytes = 3'd4;
      endcase
   end

   assign w_cross = (w_nbytes + {1'b0, i_addr[1:0]}) > 3'd4;

   always_ff @(posedge clk) begin
      if (!rst_x)
         r_words <= 2'd0;
      else if (w_accept)
         r_words <= w_cross ? 2'd2 : 2'd1;
      else if ((o_dram_rd || o_dram_wr) && (r_words != 2'd0))
         r_words <= r_words - 1'b1;
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_x)
      $onehot0({o_dram_rd, o_dram_wr, o_dram_refresh}))
      else $error("more than one DRAM strobe high in the same cycle");

   a_strobe_idle: assert property (@(posedge clk) disable iff (!rst_x)
      w_strobe |-> !i_dram_busy)
      else $error("DRAM strobe issued while the DRAM is busy");

   a_busy_accept: assert property (@(posedge clk) disable iff (!rst_x)
      (r_words != 2'd0) |-> o_busy)
      else $error("o_busy low before every word of the access was issued");

endmodule

bind unaligned_access_ctrl tb_assertions tb_assertions_inst (
   .clk(clk), .rst_x(rst_x), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en),
   .i_addr(i_addr), .i_ctrl(i_ctrl),
   .i_dram_busy(i_dram_busy), .o_busy(o_busy), .o_dram_rd(o_dram_rd),
   .o_dram_wr(o_dram_wr), .o_dram_refresh(o_dram_refresh)
);

//--- verif/tb_checker.sv
/*
 * testbench checker
 * - shadow byte memory updated by accepted stores
 * - reference load function, compare at the end of each read
 */
module tb_checker (
   input  logic            clk,
   input  logic            rst_x,
   input  logic            i_rd_en,
   input  logic            i_wr_en,
   input  logic [31:0]     i_addr,
   input  dram_pkg::word_t i_data,
   input  lsu_pkg::ctrl_t  i_ctrl,
   input  dram_pkg::word_t i_dut_data,
   input  logic            i_dut_busy,
   output int              o_checks,
   output int              o_errors
);

   logic [7:0]      shadow [4096];   // same 4 KiB as the DRAM model, little-endian
   logic            r_busy_q;
   logic            r_pend_rd;
   logic [31:0]     r_pend_addr;
   lsu_pkg::ctrl_t  r_pend_ctrl;
   dram_pkg::word_t r_expect;

   function automatic dram_pkg::word_t ref_load(input logic [31:0] addr,
                                                input lsu_pkg::ctrl_t ctrl);
      logic [31:0]     raw;
      logic            sign;
      dram_pkg::word_t res;
      for (int k = 0; k < 4; k++)
         raw[8*k +: 8] = shadow[12'(addr + 32'(k))];
      case (ctrl[1:0])
         lsu_pkg::SIZE_BYTE: begin
            sign = raw[7] & ~ctrl[lsu_pkg::UNSIGNED_BIT];
            res  = {{24{sign}}, raw[7:0]};
         end
         lsu_pkg::SIZE_HALF: begin
            sign = raw[15] & ~ctrl[lsu_pkg::UNSIGNED_BIT];
            res  = {{16{sign}}, raw[15:0]};
         end
         default: res = raw;
      endcase
      return res;
   endfunction

   task automatic apply_store(input logic [31:0] addr, input dram_pkg::word_t data,
                              input lsu_pkg::ctrl_t ctrl);
      int nbytes;
      nbytes = (ctrl[1:0] == lsu_pkg::SIZE_BYTE) ? 1 :
               (ctrl[1:0] == lsu_pkg::SIZE_HALF) ? 2 : 4;
      for (int k = 0; k < nbytes; k++)
         shadow[12'(addr + 32'(k))] = data[8*k +: 8];
   endtask

   always @(posedge clk) begin
      if (!rst_x) begin
         for (int i = 0; i < 4096; i++)
            shadow[i] = 8'h00;   // DRAM model starts zeroed
         r_busy_q  = 1'b0;
         r_pend_rd = 1'b0;
         o_checks  = 0;
         o_errors  = 0;
      end else begin
         // end of access first, a new request may be taken on the same edge
         if (r_busy_q && !i_dut_busy && r_pend_rd) begin
            o_checks++;
            if (i_dut_data !== r_expect) begin
               o_errors++;
               $display("mismatch at %0t: load ctrl %0d addr 0x%08h got 0x%08h expected 0x%08h",
                        $time, r_pend_ctrl, r_pend_addr, i_dut_data, r_expect);
            end
            r_pend_rd = 1'b0;
         end
         if (!i_dut_busy && (i_rd_en || i_wr_en)) begin
            r_pend_rd   = i_rd_en;   // read wins
            r_pend_addr = i_addr;
            r_pend_ctrl = i_ctrl;
            if (i_rd_en)
               r_expect = ref_load(i_addr, i_ctrl);
            else
               apply_store(i_addr, i_data, i_ctrl);
         end
         r_busy_q = i_dut_busy;
      end
   end

endmodule

//--- verif/tb_top.sv
/*
 * testbench top for the data memory subsystem
 * - clock, reset, directed and LCG-driven load/store stimulus
 * - DUT instance, checker instance, per-test lines and summary
 */
module tb_top;

   localparam int TIMEOUT = 2000;
   localparam int GAP     = dram_pkg::DEF_REFRESH_INTERVAL + 60;
   localparam lsu_pkg::ctrl_t LB  = {1'b0, lsu_pkg::SIZE_BYTE};
   localparam lsu_pkg::ctrl_t LH  = {1'b0, lsu_pkg::SIZE_HALF};
   localparam lsu_pkg::ctrl_t LW  = {1'b0, lsu_pkg::SIZE_WORD};
   localparam lsu_pkg::ctrl_t LBU = {1'b1, lsu_pkg::SIZE_BYTE};
   localparam lsu_pkg::ctrl_t LHU = {1'b1, lsu_pkg::SIZE_HALF};

   logic clk;
   logic rst_x;
   logic i_rd_en;
   logic i_wr_en;
   logic [31:0] i_addr;
   dram_pkg::word_t i_data;
   lsu_pkg::ctrl_t i_ctrl;
   dram_pkg::word_t o_data;
   logic o_busy;
   logic o_late_refresh;
   int n_checks;
   int n_errors;
   int n_fail = 0;
   int n_refresh;
   int refresh_base;
   int base_checks = 0;
   int base_errors = 0;
   int base_fail = 0;
   logic [31:0] lcg_state = 32'h3fda_42d6;

   dram_subsystem_top dram_subsystem_top_inst (
      .clk(clk), .rst_x(rst_x), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr),
      .i_data(i_data), .i_ctrl(i_ctrl), .o_data(o_data), .o_busy(o_busy),
      .o_late_refresh(o_late_refresh)
   );

   tb_checker tb_checker_inst (
      .clk(clk), .rst_x(rst_x), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr),
      .i_data(i_data), .i_ctrl(i_ctrl), .i_dut_data(o_data), .i_dut_busy(o_busy),
      .o_checks(n_checks), .o_errors(n_errors)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      if (!rst_x)
         n_refresh = 0;
      else if (dram_subsystem_top_inst.dram_refresh)
         n_refresh++;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic lsu_pkg::ctrl_t pick_ctrl(input logic [2:0] sel);
      lsu_pkg::ctrl_t table_c [8] = '{LB, LBU, LH, LHU, LW, LW, LB, LH};
      return table_c[sel];
   endfunction

   task automatic report_failure(input string msg);
      $display("failure at %0t: %s", $time, msg);
      n_fail++;
   endtask

   // one core access, enable held until an edge sees o_busy low
   task automatic access(input logic rd, input logic [31:0] addr, input dram_pkg::word_t data,
                         input lsu_pkg::ctrl_t ctrl);
      int cnt;
      logic busy_seen;
      logic taken;
      @(posedge clk);
      i_rd_en <= rd;
      i_wr_en <= !rd;
      i_addr  <= addr;
      i_data  <= data;
      i_ctrl  <= ctrl;
      cnt   = 0;
      taken = 1'b0;
      while (!taken && cnt < TIMEOUT) begin
         @(negedge clk);
         busy_seen = o_busy;
         @(posedge clk);
         if (!busy_seen)
            taken = 1'b1;
         else
            cnt++;
      end
      i_rd_en <= 1'b0;
      i_wr_en <= 1'b0;
      if (!taken) begin
         report_failure("request was never accepted");
      end else begin
         cnt = 0;
         @(negedge clk);
         while (!o_busy && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
         end
         if (!o_busy)
            report_failure("o_busy did not rise after the request");
         cnt = 0;
         while (o_busy && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
         end
         if (o_busy)
            report_failure("o_busy stayed high, access never finished");
      end
   endtask

   task automatic end_test(input int num, input string name);
      @(posedge clk);   // lets the checker see the last falling edge of o_busy
      @(negedge clk);
      $display("test %0d %s: %0d checks, %0d mismatches, %0d other failures", num, name,
               n_checks - base_checks, n_errors - base_errors, n_fail - base_fail);
      base_checks = n_checks;
      base_errors = n_errors;
      base_fail   = n_fail;
   endtask

   initial begin
      clk = 1'b0;
      rst_x = 1'b0;
      i_rd_en = 1'b0;
      i_wr_en = 1'b0;
      i_addr = '0;
      i_data = '0;
      i_ctrl = '0;
      repeat (4) @(posedge clk);
      rst_x <= 1'b1;

      access(0, 32'h40, 32'hdead_beef, LW);
      access(1, 32'h40, 32'h0, LW);
      access(0, 32'h44, 32'h1234_5678, LW);
      access(1, 32'h44, 32'h0, LW);
      end_test(1, "aligned word");

      access(0, 32'h80, 32'h1122_3344, LW);
      for (int off = 0; off < 4; off++) begin
         access(0, 32'h80 + 32'(off), {24'hffffff, 8'h70 + 8'(off * 48)}, LB);
         access(1, 32'h80 + 32'(off), 32'h0, LB);
         access(1, 32'h80 + 32'(off), 32'h0, LBU);
         access(1, 32'h80, 32'h0, LW);
      end
      access(0, 32'h90, 32'hcafe_f00d, LW);
      for (int off = 0; off < 3; off++) begin
         access(0, 32'h90 + 32'(off), {16'h5555, 16'h4000 + 16'(off * 16'h2345)}, LH);
         access(1, 32'h90 + 32'(off), 32'h0, LH);
         access(1, 32'h90 + 32'(off), 32'h0, LHU);
         access(1, 32'h90, 32'h0, LW);
      end
      end_test(2, "byte and half lanes");

      access(0, 32'ha3, 32'h0000_8765, LH);
      access(1, 32'ha3, 32'h0, LH);
      access(1, 32'ha3, 32'h0, LHU);
      for (int off = 1; off < 4; off++) begin
         access(0, 32'hb0 + 32'(off * 16 + off), 32'h8a9b_0c1d + 32'(off), LW);
         access(1, 32'hb0 + 32'(off * 16 + off), 32'h0, LW);
         access(1, 32'hb0 + 32'(off * 16), 32'h0, LW);   // both words it touched
         access(1, 32'hb4 + 32'(off * 16), 32'h0, LW);
      end
      access(1, 32'ha0, 32'h0, LW);
      access(1, 32'ha4, 32'h0, LW);
      end_test(3, "word-crossing accesses");

      for (int g = 0; g < 3; g++) begin
         refresh_base = n_refresh;
         repeat (GAP) @(posedge clk);   // idle long enough for the timer to ask
         if (n_refresh == refresh_base)
            report_failure("no refresh happened during an idle gap");
         access(0, 32'h60 + 32'(g), 32'h3c5a_0f00 + 32'(g), LW);
         access(1, 32'h60 + 32'(g), 32'h0, LW);
      end
      if (o_late_refresh)
         report_failure("late refresh flag is set");
      end_test(4, "refresh between accesses");

      for (int i = 0; i < 300; i++) begin
         logic        rd;
         logic [31:0] addr;
         logic [31:0] data;
         lcg_state = lcg_next(lcg_state);
         rd = lcg_state[31];
         lcg_state = lcg_next(lcg_state);
         addr = {24'h0, lcg_state[23:16]};   // first 64 words
         lcg_state = lcg_next(lcg_state);
         data = lcg_state;
         lcg_state = lcg_next(lcg_state);
         access(rd, addr, data, pick_ctrl(lcg_state[30:28]));
      end
      if (o_late_refresh)
         report_failure("late refresh flag is set after the random run");
      end_test(5, "random mix");

      $display("summary: %0d checks, %0d mismatches, %0d other failures",
               n_checks, n_errors, n_fail);
      if (n_errors == 0 && n_fail == 0 && n_checks > 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

//--- sim.f
verilog/lsu_pkg.sv
verilog/dram_pkg.sv
verilog/refresh_timer.sv
verilog/word_dram_model.sv
verilog/load_align.sv
verilog/unaligned_access_ctrl.sv
verilog/dram_subsystem_top.sv
verif/tb_assertions.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the data memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f sim.f

output=$(./obj_dir/Vtb_top)
echo "$output"

if grep -q "Regression passed" <<< "$output"; then
   exit 0
else
   exit 1
fi
